//--- source/gateway_pkg.sv
// ======================================================================
// shared widths, field positions and enums of the UDP memory gateway
// the control+address word is big endian, address in the low 24 bits
// only the read flag of the 8 control bits is decoded
// ======================================================================

package gateway_pkg;

	// local bus address width, the low bits of the control+address word
	localparam int unsigned addr_w = 24;

	// local bus data width, also the size of each half of a transaction
	localparam int unsigned data_w = 32;

	// position of the read flag inside the 32-bit control+address word
	// a set bit asks for a read, a clear bit for a write
	localparam int unsigned rd_bit = 28;

	// framing of the incoming byte stream
	// a packet opens with 8 padding bytes and then carries 8-byte transactions
	typedef enum logic [1:0] {
		// outside a packet, raw_s low
		FR_IDLE = 2'd0,
		// inside the leading padding bytes
		FR_PAD  = 2'd1,
		// inside the transaction body
		FR_BODY = 2'd2
	} frame_state_e;

	// bus operation decoded from the read flag
	// the encoding matches the flag so that a read is the set bit
	typedef enum logic {
		LB_WRITE = 1'b0,
		LB_READ  = 1'b1
	} lb_op_e;

endpackage

//--- source/lb_if.sv
// ======================================================================
// local bus between the gateway and its register target
// strobe is a single-cycle pulse per transaction, rd and addr hold
// until the next strobe, no handshake and no back-pressure
// ======================================================================

`timescale 1ns/1ps

interface lb_if;

	// address and write data, held from one strobe to the next
	logic [gateway_pkg::addr_w-1:0] addr;
	logic [gateway_pkg::data_w-1:0] data_out;
	// one pulse per transaction
	logic strobe;
	// level that tells a read from a write
	logic rd;
	// strobe qualified by rd being clear
	logic write;
	// read return, a fixed number of cycles after the read strobe
	logic rd_valid;
	logic [gateway_pkg::data_w-1:0] data_in;

	// the gateway side issues every transaction
	modport master (output addr, data_out, strobe, rd, write);

	// the register side answers reads and takes writes
	modport target (input addr, data_out, strobe, rd, write,
		output rd_valid, data_in);

	// the reply path only needs the returned read data
	modport observer (input rd_valid, data_in);

endinterface

//--- source/byte_delay.sv
// ======================================================================
// fixed byte delay line with synchronous clear
// delays din by exactly len cycles, len of zero passes din straight
// through with no register at all
// ======================================================================

`timescale 1ns/1ps

module byte_delay #(
	parameter int unsigned len = 1
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] din,
	output logic [7:0] dout
);

	generate
		if (len == 0) begin : g_pass
			// zero length leaves the alignment to the stages around it
			assign dout = din;
		end else begin : g_chain
			// one byte register per cycle of delay
			logic [7:0] taps [len];

			always_ff @(posedge clk) begin
				if (!rst_n) begin
					for (int i = 0; i < int'(len); i++) begin
						taps[i] <= 8'd0;
					end
				end else begin
					taps[0] <= din;
					// every tap takes the value of the one before it
					for (int i = 1; i < int'(len); i++) begin
						taps[i] <= taps[i-1];
					end
				end
			end

			assign dout = taps[len-1];
		end
	endgenerate

endmodule

//--- source/cmd_assembler.sv
// ======================================================================
// frames the packet bytes and turns each 8-byte transaction into one
// local bus strobe, the lead 8 bytes of a packet are padding
// a transaction cut short by raw_s going low issues nothing
// ======================================================================

`timescale 1ns/1ps

module cmd_assembler (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] idata,
	input  logic       raw_s,
	lb_if.master       bus
);

	// byte history, the newest byte sits in the low 8 bits
	logic [2*gateway_pkg::data_w-1:0] isr;
	logic [2*gateway_pkg::data_w-1:0] isr_next;
	// position of the current byte inside its 8-byte group
	logic [2:0] c8;
	gateway_pkg::frame_state_e state;
	gateway_pkg::frame_state_e state_next;
	logic last_byte;
	logic do_op;
	gateway_pkg::lb_op_e op_next;
	gateway_pkg::lb_op_e op_r;
	logic strobe_r;
	// latched fields of the current transaction
	logic [gateway_pkg::addr_w-1:0] addr_r;
	logic [gateway_pkg::data_w-1:0] data_r;

	assign isr_next = {isr[2*gateway_pkg::data_w-9:0], idata};

	// the 8th byte of a group must still be inside the packet to count
	assign last_byte = raw_s && (c8 == 3'd7);
	assign do_op = (state == gateway_pkg::FR_BODY) && last_byte;

	// the read flag lives in the control+address half, the upper 32 bits
	assign op_next = isr_next[gateway_pkg::data_w + gateway_pkg::rd_bit] ?
		gateway_pkg::LB_READ : gateway_pkg::LB_WRITE;

	always_comb begin
		state_next = state;
		if (!raw_s) begin
			// one low cycle ends the packet whatever came before
			state_next = gateway_pkg::FR_IDLE;
		end else begin
			case (state)
				gateway_pkg::FR_IDLE: state_next = gateway_pkg::FR_PAD;
				gateway_pkg::FR_PAD: begin
					if (last_byte) begin
						state_next = gateway_pkg::FR_BODY;
					end
				end
				gateway_pkg::FR_BODY: state_next = gateway_pkg::FR_BODY;
				default: state_next = gateway_pkg::FR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= gateway_pkg::FR_IDLE;
			c8 <= 3'd0;
			isr <= '0;
			strobe_r <= 1'b0;
			op_r <= gateway_pkg::LB_WRITE;
		end else begin
			state <= state_next;
			// the count restarts with every packet
			c8 <= raw_s ? c8 + 3'd1 : 3'd0;
			isr <= isr_next;
			strobe_r <= do_op;
			if (do_op) begin
				op_r <= op_next;
			end
		end
	end

	// address and data only change together with a strobe
	always_ff @(posedge clk) begin
		if (do_op) begin
			addr_r <= isr_next[gateway_pkg::data_w +: gateway_pkg::addr_w];
			data_r <= isr_next[gateway_pkg::data_w-1:0];
		end
	end

	assign bus.addr = addr_r;
	assign bus.data_out = data_r;
	assign bus.strobe = strobe_r;
	assign bus.rd = (op_r == gateway_pkg::LB_READ);
	assign bus.write = strobe_r && (op_r == gateway_pkg::LB_WRITE);

endmodule

//--- source/reg_bank.sv
// ======================================================================
// register array on the local bus, cleared by reset
// only the low reg_depth_log2 address bits decode, higher ones alias
// read data returns read_pipe_len cycles after the strobe, reads may overlap
// ======================================================================

`timescale 1ns/1ps

module reg_bank #(
	parameter int unsigned read_pipe_len  = 3,
	parameter int unsigned reg_depth_log2 = 4
) (
	input  logic clk,
	input  logic rst_n,
	lb_if.target bus
);

	localparam int unsigned depth = 2 ** reg_depth_log2;

	logic [gateway_pkg::data_w-1:0] regs [depth];
	logic [reg_depth_log2-1:0] idx;
	logic rd_start;
	// one valid bit and one data word per pipeline stage
	logic [read_pipe_len-1:0] pipe_vld;
	logic [read_pipe_len:0] vld_next;
	logic [gateway_pkg::data_w-1:0] pipe_data [read_pipe_len];

	assign idx = bus.addr[reg_depth_log2-1:0];
	assign rd_start = bus.strobe && bus.rd;

	// stage 0 takes the new read marker, the oldest stage falls off the top
	assign vld_next = {pipe_vld, rd_start};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pipe_vld <= '0;
			for (int i = 0; i < int'(depth); i++) begin
				regs[i] <= '0;
			end
		end else begin
			pipe_vld <= vld_next[read_pipe_len-1:0];
			// write lands at the edge that closes its strobe cycle
			if (bus.write) begin
				regs[idx] <= bus.data_out;
			end
		end
	end

	// the data words move every cycle, the valid bits mark the real reads
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < int'(read_pipe_len); i++) begin
				pipe_data[i] <= '0;
			end
		end else begin
			// sampled at the strobe edge, so the read sees the array as it was
			pipe_data[0] <= regs[idx];
			for (int i = 1; i < int'(read_pipe_len); i++) begin
				pipe_data[i] <= pipe_data[i-1];
			end
		end
	end

	assign bus.rd_valid = pipe_vld[read_pipe_len-1];
	assign bus.data_in = pipe_data[read_pipe_len-1];

endmodule

//--- source/reply_builder.sv
// ======================================================================
// rebuilds the outgoing byte stream with read data spliced in
// every byte leaves n_lat cycles after it entered
// n_lat must be at least read_pipe_len + 5
// ======================================================================

`timescale 1ns/1ps

module reply_builder #(
	parameter int unsigned read_pipe_len = 3,
	parameter int unsigned n_lat         = 8
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] idata,
	lb_if.observer     bus,
	output logic [7:0] odata
);

	// bytes lined up with the read return of the bus
	logic [7:0] pdata;
	// output shift register, the top byte is the next one to go out
	logic [gateway_pkg::data_w-1:0] osr;
	logic [7:0] xdata;

	// the extra cycle covers the registered strobe in the command stage
	byte_delay #(
		.len(read_pipe_len + 1)
	) align (
		.clk(clk),
		.rst_n(rst_n),
		.din(idata),
		.dout(pdata)
	);

	// reads in flight are carried by the bus target pipeline
	// each rd_valid pulse lands right as the four data bytes of its
	// own transaction fill the shift register, so a load replaces them
	// and overlapping reads can never mix their words
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			osr <= '0;
		end else if (bus.rd_valid) begin
			osr <= bus.data_in;
		end else begin
			osr <= {osr[gateway_pkg::data_w-9:0], pdata};
		end
	end

	assign xdata = osr[gateway_pkg::data_w-1 -: 8];

	// the remaining cycles of latency, may be none at the minimum n_lat
	byte_delay #(
		.len(n_lat - read_pipe_len - 5)
	) finale (
		.clk(clk),
		.rst_n(rst_n),
		.din(xdata),
		.dout(odata)
	);

endmodule

//--- source/mem_gateway_top.sv
// ======================================================================
// UDP payload to local register bus gateway with its own register bank
// packets are framed by raw_s, one byte per clock, no back-pressure
// n_lat must be at least read_pipe_len + 5, read_pipe_len at least 1
// ======================================================================

`timescale 1ns/1ps

module mem_gateway_top #(
	parameter int unsigned read_pipe_len  = 3,
	parameter int unsigned n_lat          = 8,
	parameter int unsigned reg_depth_log2 = 4
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] idata,
	input  logic       raw_s,
	output logic [7:0] odata
);

	// local bus shared by the three stages
	lb_if lb ();

	// turns framed bytes into bus transactions
	cmd_assembler u_cmd (
		.clk(clk),
		.rst_n(rst_n),
		.idata(idata),
		.raw_s(raw_s),
		.bus(lb.master)
	);

	// answers the transactions with a fixed read latency
	reg_bank #(
		.read_pipe_len(read_pipe_len),
		.reg_depth_log2(reg_depth_log2)
	) u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.bus(lb.target)
	);

	// echoes the stream and splices the read data back in
	reply_builder #(
		.read_pipe_len(read_pipe_len),
		.n_lat(n_lat)
	) u_reply (
		.clk(clk),
		.rst_n(rst_n),
		.idata(idata),
		.bus(lb.observer),
		.odata(odata)
	);

endmodule

//--- dv/tb_mem_gateway.sv
// ======================================================================
// self-checking testbench for the UDP memory gateway, default parameters
// a reference model predicts every odata byte n_lat cycles ahead
// stimulus is seeded and repeatable, the run stops at a cycle limit
// ======================================================================

`timescale 1ns/1ps

module tb_mem_gateway;

	localparam int unsigned read_pipe_len  = 3;
	localparam int unsigned n_lat          = 8;
	localparam int unsigned reg_depth_log2 = 4;
	localparam int unsigned num_regs       = 2 ** reg_depth_log2;

	// reset, zero bytes, loose bytes, then packets of 89, 57, 16 and 33 bytes
	localparam int unsigned stim_cycles = 2 + 12 + 6 + 89 + 57 + 16 + 33;
	localparam int unsigned cycle_limit = 2 * (stim_cycles + n_lat);

	logic       clk;
	logic       rst_n;
	logic [7:0] idata;
	logic       raw_s;
	logic [7:0] odata;

	integer      seed;
	int unsigned cyc;
	int unsigned errors;
	int unsigned checks;

	// expected bytes and the cycle on which each must sit on odata
	logic [7:0]  exp_bytes [$];
	int unsigned exp_stamps [$];
	// byte under check for the current cycle, set at the rising edge
	logic       chk_en;
	logic [7:0] chk_byte;

	// shadow copy of the register bank
	logic [31:0] shadow [num_regs];
	// position inside the current packet, counted from the first padding byte
	int          pkt_pos;
	logic [63:0] txn;
	logic [23:0] addrs [4];

	mem_gateway_top #(
		.read_pipe_len(read_pipe_len),
		.n_lat(n_lat),
		.reg_depth_log2(reg_depth_log2)
	) dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.idata(idata),
		.raw_s(raw_s),
		.odata(odata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// every byte is echoed, only the data field of a completed read is
	// replaced with the shadow word, big endian
	function automatic void model_byte(input logic [7:0] b, input logic s);
		logic [31:0] ctrl;
		logic [31:0] word;
		int n;
		exp_bytes.push_back(b);
		exp_stamps.push_back(cyc + n_lat);
		if (!s) begin
			pkt_pos = 0;
		end else begin
			txn = {txn[55:0], b};
			// padding takes positions 0 to 7, then a transaction ends every 8 bytes
			if (pkt_pos >= 8 && (pkt_pos % 8) == 7) begin
				ctrl = txn[63:32];
				if (ctrl[gateway_pkg::rd_bit]) begin
					word = shadow[ctrl[reg_depth_log2-1:0]];
					n = exp_bytes.size();
					for (int i = 0; i < 4; i++) begin
						exp_bytes[n-4+i] = word[31-8*i -: 8];
					end
				end else begin
					shadow[ctrl[reg_depth_log2-1:0]] = txn[31:0];
				end
			end
			pkt_pos++;
		end
	endfunction

	// one byte per falling edge, the model sees it in the same step
	task automatic put_byte(input logic [7:0] b, input logic s);
		@(negedge clk);
		idata = b;
		raw_s = s;
		model_byte(b, s);
	endtask

	task automatic emit_word(input logic [31:0] w);
		for (int i = 0; i < 4; i++) begin
			put_byte(w[31-8*i -: 8], 1'b1);
		end
	endtask

	task automatic pad_packet();
		logic [31:0] r;
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			put_byte(r[7:0], 1'b1);
		end
	endtask

	// a single low byte ends the packet
	task automatic close_packet();
		logic [31:0] r;
		r = $random(seed);
		put_byte(r[7:0], 1'b0);
	endtask

	// random upper address bits above the decoded register index
	function automatic logic [23:0] rand_addr(input int unsigned idx);
		logic [31:0] r;
		logic [23:0] a;
		r = $random(seed);
		a = r[23:0];
		a[reg_depth_log2-1:0] = idx[reg_depth_log2-1:0];
		return a;
	endfunction

	// the other control bits are random, only the read flag matters
	task automatic issue_txn(input logic is_read, input logic [23:0] addr);
		logic [31:0] ctrl;
		logic [31:0] data;
		ctrl = $random(seed);
		ctrl[gateway_pkg::addr_w-1:0] = addr;
		ctrl[gateway_pkg::rd_bit] = is_read;
		data = $random(seed);
		emit_word(ctrl);
		emit_word(data);
	endtask

	// a write that loses its last data byte when raw_s drops
	task automatic cut_txn(input logic [23:0] addr);
		logic [31:0] ctrl;
		logic [31:0] data;
		ctrl = $random(seed);
		ctrl[gateway_pkg::addr_w-1:0] = addr;
		ctrl[gateway_pkg::rd_bit] = 1'b0;
		data = $random(seed);
		emit_word(ctrl);
		for (int i = 0; i < 3; i++) begin
			put_byte(data[31-8*i -: 8], 1'b1);
		end
	endtask

	// picks the expected byte due in the cycle that starts at this edge
	always @(posedge clk) begin
		cyc = cyc + 1;
		chk_en = 1'b0;
		if (exp_stamps.size() > 0 && exp_stamps[0] == cyc) begin
			chk_en = 1'b1;
			chk_byte = exp_bytes.pop_front();
			void'(exp_stamps.pop_front());
			checks++;
		end
		if (cyc > cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// odata is stable in mid cycle, half a period after it changed
	odata_matches: assert property (@(negedge clk) chk_en |-> (odata === chk_byte))
		else begin
			errors++;
			$display("CHECK FAILED at %0t: odata = %02h, expected %02h",
				$time, odata, chk_byte);
		end

	initial begin
		logic [31:0] r;
		rst_n = 1'b0;
		idata = 8'h00;
		raw_s = 1'b0;
		seed = 2638;
		cyc = 0;
		errors = 0;
		checks = 0;
		chk_en = 1'b0;
		chk_byte = 8'h00;
		pkt_pos = 0;
		txn = '0;
		for (int i = 0; i < int'(num_regs); i++) begin
			shadow[i] = '0;
		end

		// the reset edges are cycles 1 and 2, odata stays zero until the first byte returns
		for (int unsigned c = 3; c <= n_lat; c++) begin
			exp_bytes.push_back(8'h00);
			exp_stamps.push_back(c);
		end

		// reset spans two rising edges, odata must stay zero on zero input
		repeat (2) put_byte(8'h00, 1'b0);
		rst_n = 1'b1;
		repeat (12) put_byte(8'h00, 1'b0);

		// loose bytes between packets are echoed
		repeat (6) begin
			r = $random(seed);
			put_byte(r[7:0], 1'b0);
		end

		// writes, readbacks, an aliased read and a never written register
		pad_packet();
		for (int i = 0; i < 4; i++) begin
			addrs[i] = rand_addr(i * 3);
			issue_txn(1'b0, addrs[i]);
		end
		for (int i = 0; i < 4; i++) begin
			issue_txn(1'b1, addrs[i]);
		end
		issue_txn(1'b1, addrs[1] ^ (24'h1 << reg_depth_log2));
		issue_txn(1'b1, rand_addr(14));
		close_packet();

		// back-to-back reads, each word belongs in its own data field
		pad_packet();
		for (int i = 0; i < 6; i++) begin
			issue_txn(1'b1, addrs[i % 4]);
		end
		close_packet();

		// a write cut short must leave the register untouched
		pad_packet();
		cut_txn(addrs[1]);
		close_packet();

		// the next packet is framed from its first byte again
		pad_packet();
		issue_txn(1'b1, addrs[1]);
		addrs[0] = rand_addr(14);
		issue_txn(1'b0, addrs[0]);
		issue_txn(1'b1, addrs[0] ^ (24'h1 << reg_depth_log2));
		close_packet();

		// idle input until every predicted byte has been compared
		while (exp_bytes.size() != 0) begin
			@(negedge clk);
		end
		@(posedge clk);

		$display("summary: %0d bytes compared, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
source/gateway_pkg.sv
source/lb_if.sv
source/byte_delay.sv
source/cmd_assembler.sv
source/reg_bank.sv
source/reply_builder.sv
source/mem_gateway_top.sv
dv/tb_mem_gateway.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the gateway testbench with Verilator
# the run passes only when the log holds the pass line of the testbench

cd "$(dirname "$0")" || exit 1

top=tb_mem_gateway
mdir=obj_dir
log=sim.log

echo "compiling with verilator"
verilator --binary --timing --assert \
	--top-module "$top" \
	--Mdir "$mdir" \
	-o "$top" \
	-f all.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "error: verilator build failed with status $status"
	exit 1
fi

echo "running simulation"
"./$mdir/$top" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
	echo "error: simulation exited with status $status"
	exit 1
fi

# the testbench prints the pass message alone on its own line
if grep -qx "ALL CHECKS PASSED" "$log"; then
	echo "result: pass"
	exit 0
else
	echo "result: fail"
	exit 1
fi
